// File: src/bod_pkg.sv
`default_nettype none

package bod_pkg;

  // ------------------------------------------------------------------
  // Bus and data widths
  // ------------------------------------------------------------------
  localparam int unsigned ADDR_W = 5;   // APB byte address
  localparam int unsigned DATA_W = 32;  // APB data word
  localparam int unsigned CODE_W = 8;   // Supply code and thresholds

  // ------------------------------------------------------------------
  // Monitor and sequencer timing
  // ------------------------------------------------------------------
  localparam int unsigned DEBOUNCE_CYCLES  = 4;  // Samples below threshold to flag
  localparam int unsigned BOR_PULSE_CYCLES = 8;  // Reset request length

  localparam logic [CODE_W-1:0] HYST_CODES = 8'd4;  // Release margin above threshold

  // Counter widths and terminal counts
  localparam int unsigned DEB_CNT_W   = $clog2(DEBOUNCE_CYCLES);
  localparam int unsigned PULSE_CNT_W = $clog2(BOR_PULSE_CYCLES);

  localparam logic [DEB_CNT_W-1:0]   DEB_LAST   = DEB_CNT_W'(DEBOUNCE_CYCLES - 1);
  localparam logic [PULSE_CNT_W-1:0] PULSE_LAST = PULSE_CNT_W'(BOR_PULSE_CYCLES - 1);

  // ------------------------------------------------------------------
  // Register map, one word per register
  // ------------------------------------------------------------------
  typedef enum logic [ADDR_W-1:0] {
    REG_V_TH1      = 5'h00,  // Warning threshold
    REG_V_TH2      = 5'h04,  // Critical threshold
    REG_STATUS     = 5'h08,  // bit0 sticky warn W1C, bit1 live warn
    REG_CTRL       = 5'h0C,  // bit0 interrupt enable
    REG_BOR_CLR    = 5'h10,  // Write 1 clears BOR event
    REG_BOR_STATUS = 5'h14   // bit0 BOR event, bit1 live critical
  } bod_reg_e;

  // BOR sequencer states
  typedef enum logic [1:0] {
    BOR_IDLE  = 2'd0,  // Armed, waiting for vcrit rise
    BOR_PULSE = 2'd1,  // Reset request active
    BOR_HOLD  = 2'd2   // Waiting for supply recovery
  } bor_state_e;

endpackage

`default_nettype wire

// File: src/bod_mon_if.sv
`default_nettype none

interface bod_mon_if;

  // Thresholds from the register block
  logic [bod_pkg::CODE_W-1:0] v_th1;  // Warning level
  logic [bod_pkg::CODE_W-1:0] v_th2;  // Critical level

  // Debounced monitor flags
  logic vwarn;  // Supply below v_th1
  logic vcrit;  // Supply below v_th2

  // BOR event handshake
  logic bor_event;  // Sticky event from sequencer
  logic bor_clr;    // One-cycle software clear

  // ------------------------------------------------------------------
  // Views per block
  // ------------------------------------------------------------------
  modport regs (
    output v_th1, v_th2, bor_clr,
    input  vwarn, vcrit, bor_event
  );

  modport mon (
    input  v_th1, v_th2,
    output vwarn, vcrit
  );

  modport seq (
    input  vcrit, bor_clr,
    output bor_event
  );

endinterface

`default_nettype wire

// File: src/bod_regs.sv
`default_nettype none

module bod_regs (
  input  logic                       CLK,
  input  logic                       RST_N,

  // APB slave
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [bod_pkg::ADDR_W-1:0] paddr,
  input  logic [bod_pkg::DATA_W-1:0] pwdata,
  output logic [bod_pkg::DATA_W-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,

  output logic                       bod_int,  // Warning interrupt to CPU

  bod_mon_if.regs                    mon_if
);

  // ------------------------------------------------------------------
  // Register storage
  // ------------------------------------------------------------------
  logic [bod_pkg::CODE_W-1:0] v_th1_q;      // Warning threshold
  logic [bod_pkg::CODE_W-1:0] v_th2_q;      // Critical threshold
  logic                       warn_sticky;  // Latched vwarn
  logic                       int_en;       // Interrupt enable
  logic                       bor_clr_q;    // Clear strobe to sequencer

  // Access decode
  logic access;     // Access phase of any transfer
  logic wr_en;      // Access phase write
  logic rd_en;      // Access phase read
  logic addr_hit;   // Offset is in the map

  logic wr_th1;
  logic wr_th2;
  logic wr_status;
  logic wr_ctrl;
  logic wr_bor_clr;

  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;

  // Offset match against the register map
  always_comb begin
    case (paddr)
      bod_pkg::REG_V_TH1,
      bod_pkg::REG_V_TH2,
      bod_pkg::REG_STATUS,
      bod_pkg::REG_CTRL,
      bod_pkg::REG_BOR_CLR,
      bod_pkg::REG_BOR_STATUS: addr_hit = 1'b1;
      default:                 addr_hit = 1'b0;
    endcase
  end

  // Per-register write strobes
  assign wr_th1     = wr_en & (paddr == bod_pkg::REG_V_TH1);
  assign wr_th2     = wr_en & (paddr == bod_pkg::REG_V_TH2);
  assign wr_status  = wr_en & (paddr == bod_pkg::REG_STATUS);
  assign wr_ctrl    = wr_en & (paddr == bod_pkg::REG_CTRL);
  assign wr_bor_clr = wr_en & (paddr == bod_pkg::REG_BOR_CLR);

  // ------------------------------------------------------------------
  // Register updates
  // ------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      v_th1_q     <= '0;    // Monitors quiet out of reset
      v_th2_q     <= '0;
      warn_sticky <= 1'b0;
      int_en      <= 1'b1;  // Interrupt enabled by default
      bor_clr_q   <= 1'b0;
    end else begin
      if (wr_th1) v_th1_q <= pwdata[bod_pkg::CODE_W-1:0];
      if (wr_th2) v_th2_q <= pwdata[bod_pkg::CODE_W-1:0];
      if (wr_ctrl) int_en <= pwdata[0];

      // Live warning beats a W1C in the same cycle
      if (mon_if.vwarn) begin
        warn_sticky <= 1'b1;
      end else if (wr_status && pwdata[0]) begin
        warn_sticky <= 1'b0;
      end

      bor_clr_q <= wr_bor_clr & pwdata[0];  // High only the cycle after the write
    end
  end

  // ------------------------------------------------------------------
  // Read mux and response
  // ------------------------------------------------------------------
  always_comb begin
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        bod_pkg::REG_V_TH1:      prdata[bod_pkg::CODE_W-1:0] = v_th1_q;
        bod_pkg::REG_V_TH2:      prdata[bod_pkg::CODE_W-1:0] = v_th2_q;
        bod_pkg::REG_STATUS:     prdata[1:0] = {mon_if.vwarn, warn_sticky};
        bod_pkg::REG_CTRL:       prdata[0]   = int_en;
        bod_pkg::REG_BOR_STATUS: prdata[1:0] = {mon_if.vcrit, mon_if.bor_event};
        default:                 prdata = '0;  // BOR_CLR and holes read 0
      endcase
    end
  end

  assign pready  = 1'b1;                 // No wait states
  assign pslverr = access & ~addr_hit;   // Unmapped offset

  // Outputs
  assign bod_int        = warn_sticky & int_en;
  assign mon_if.v_th1   = v_th1_q;
  assign mon_if.v_th2   = v_th2_q;
  assign mon_if.bor_clr = bor_clr_q;

endmodule

`default_nettype wire

// File: src/bod_monitor.sv
`default_nettype none

module bod_monitor (
  input  logic                       CLK,
  input  logic                       RST_N,
  input  logic [bod_pkg::CODE_W-1:0] vdd_code,  // Digitised supply level

  bod_mon_if.mon                     mon_if
);

  // ------------------------------------------------------------------
  // Channel 0 is warning, channel 1 is critical
  // ------------------------------------------------------------------
  localparam int unsigned NUM_CH = 2;

  logic [NUM_CH-1:0][bod_pkg::CODE_W-1:0] th;  // Threshold per channel
  wire  [NUM_CH-1:0]                      flag; // Filtered flag per channel

  assign th = {mon_if.v_th2, mon_if.v_th1};

  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_chan
    logic [bod_pkg::DEB_CNT_W-1:0] deb_cnt;   // Consecutive low samples
    logic                          flag_q;
    logic                          below;     // Sample under threshold
    logic [bod_pkg::CODE_W:0]      rel_lvl;   // Threshold plus hysteresis
    logic                          release_ok;

    assign below = (vdd_code < th[ch]);

    // One extra bit so a high threshold cannot wrap
    assign rel_lvl    = {1'b0, th[ch]} + {1'b0, bod_pkg::HYST_CODES};
    assign release_ok = ({1'b0, vdd_code} >= rel_lvl);

    // Debounce counter saturates at the last step
    always_ff @(posedge CLK or negedge RST_N) begin
      if (!RST_N) begin
        deb_cnt <= '0;
      end else if (!below) begin
        deb_cnt <= '0;                 // Any good sample restarts the count
      end else if (deb_cnt != bod_pkg::DEB_LAST) begin
        deb_cnt <= deb_cnt + 1'b1;
      end
    end

    // Flag sets on the Nth low sample
    always_ff @(posedge CLK or negedge RST_N) begin
      if (!RST_N) begin
        flag_q <= 1'b0;
      end else if (below && (deb_cnt == bod_pkg::DEB_LAST)) begin
        flag_q <= 1'b1;
      end else if (release_ok) begin
        flag_q <= 1'b0;               // Only clears clear of the band
      end
    end

    assign flag[ch] = flag_q;
  end

  // Between th and th+HYST the flag keeps its value

  assign mon_if.vwarn = flag[0];
  assign mon_if.vcrit = flag[1];

endmodule

`default_nettype wire

// File: src/bod_bor_seq.sv
`default_nettype none

module bod_bor_seq (
  input  logic   CLK,
  input  logic   RST_N,
  output logic   bor_rst_req,  // Reset request to the PMU

  bod_mon_if.seq mon_if
);

  bod_pkg::bor_state_e state;
  bod_pkg::bor_state_e state_d;

  logic [bod_pkg::PULSE_CNT_W-1:0] pulse_cnt;  // Cycles spent in PULSE
  logic                            vcrit_q;    // Previous vcrit
  logic                            vcrit_rise;
  logic                            bor_event_q;
  logic                            event_set;

  assign vcrit_rise = mon_if.vcrit & ~vcrit_q;
  assign event_set  = (state == bod_pkg::BOR_IDLE) & vcrit_rise;

  // ------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------
  always_comb begin
    state_d = state;
    case (state)
      bod_pkg::BOR_IDLE:  if (vcrit_rise) state_d = bod_pkg::BOR_PULSE;
      bod_pkg::BOR_PULSE: if (pulse_cnt == bod_pkg::PULSE_LAST) state_d = bod_pkg::BOR_HOLD;
      bod_pkg::BOR_HOLD:  if (!mon_if.vcrit) state_d = bod_pkg::BOR_IDLE;  // Re-arm
      default:            state_d = bod_pkg::BOR_IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      state     <= bod_pkg::BOR_IDLE;
      pulse_cnt <= '0;
      vcrit_q   <= 1'b0;
    end else begin
      state   <= state_d;
      vcrit_q <= mon_if.vcrit;
      // Counts only while the request is out
      if (state == bod_pkg::BOR_PULSE) pulse_cnt <= pulse_cnt + 1'b1;
      else                             pulse_cnt <= '0;
    end
  end

  // ------------------------------------------------------------------
  // Sticky event flag
  // ------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RST_N) begin
    if (!RST_N) begin
      bor_event_q <= 1'b0;
    end else if (event_set) begin
      bor_event_q <= 1'b1;   // New event wins over clear
    end else if (mon_if.bor_clr) begin
      bor_event_q <= 1'b0;
    end
  end

  assign bor_rst_req      = (state == bod_pkg::BOR_PULSE);
  assign mon_if.bor_event = bor_event_q;

endmodule

`default_nettype wire

// File: src/bod_top.sv
`default_nettype none

module bod_top (
  input  logic                       CLK,
  input  logic                       RST_N,

  // ------------------------------------------------------------------
  // APB slave port
  // ------------------------------------------------------------------
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [bod_pkg::ADDR_W-1:0] paddr,
  input  logic [bod_pkg::DATA_W-1:0] pwdata,
  output logic [bod_pkg::DATA_W-1:0] prdata,
  output logic                       pready,
  output logic                       pslverr,

  // ------------------------------------------------------------------
  // Supply and PMU side
  // ------------------------------------------------------------------
  input  logic [bod_pkg::CODE_W-1:0] vdd_code,     // Synchronous to CLK
  output logic                       bod_int,      // Warning interrupt
  output logic                       bor_rst_req   // Brownout reset request
);

  // Thresholds, flags and BOR handshake between the blocks
  bod_mon_if mon_if ();

  // Software view
  bod_regs regs_i (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .bod_int (bod_int),
    .mon_if  (mon_if.regs)
  );

  // Debounced comparators
  bod_monitor mon_i (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .vdd_code (vdd_code),
    .mon_if   (mon_if.mon)
  );

  // Critical undervoltage to reset pulse
  bod_bor_seq seq_i (
    .CLK         (CLK),
    .RST_N       (RST_N),
    .bor_rst_req (bor_rst_req),
    .mon_if      (mon_if.seq)
  );

endmodule

`default_nettype wire

// File: dv/bod_props.sv
`default_nettype none

module bod_props (
  input logic                CLK,
  input logic                RST_N,
  input logic                pready,
  input logic                pslverr,
  input logic                bod_int,
  input logic                bor_rst_req,
  input logic                vwarn,        // Live monitor flags
  input logic                vcrit,
  input logic                int_en,       // From the register block
  input logic                bor_clr,      // Clear strobe to the sequencer
  input bod_pkg::bor_state_e state         // BOR FSM state
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  // ------------------------------------------------------------------
  // APB and interrupt
  // ------------------------------------------------------------------
  a_pready: assert property (@(posedge CLK) disable iff (!RST_N) pready)
    else begin
      fail_cnt++;
      $error("pready is not 1");
    end

  // Sticky warning sets one cycle after vwarn, interrupt follows it
  a_int_set: assert property (@(posedge CLK) disable iff (!RST_N)
    (int_en && $past(vwarn)) |-> bod_int)
    else begin
      fail_cnt++;
      $error("bod_int low one cycle after a warning while enabled");
    end

  a_int_mask: assert property (@(posedge CLK) disable iff (!RST_N)
    !int_en |-> !bod_int)
    else begin
      fail_cnt++;
      $error("bod_int high while the interrupt is disabled");
    end

  // ------------------------------------------------------------------
  // BOR sequencer
  // ------------------------------------------------------------------
  a_pulse_len: assert property (@(posedge CLK) disable iff (!RST_N)
    $rose(bor_rst_req) |-> bor_rst_req [*bod_pkg::BOR_PULSE_CYCLES] ##1 !bor_rst_req)
    else begin
      fail_cnt++;
      $error("bor_rst_req pulse length is wrong");
    end

  // A pulse starts only from IDLE, one edge after vcrit rose
  a_no_retrig: assert property (@(posedge CLK) disable iff (!RST_N)
    $rose(bor_rst_req) |->
      $past(state == bod_pkg::BOR_IDLE) && $past(vcrit) && !$past(vcrit, 2))
    else begin
      fail_cnt++;
      $error("BOR sequencer retriggered without a new vcrit rise");
    end

  // First edge out of reset
  a_quiet: assert property (@(posedge CLK)
    $rose(RST_N) |-> !bod_int && !bor_rst_req && !pslverr && !bor_clr)
    else begin
      fail_cnt++;
      $error("outputs not quiet after reset");
    end

endmodule

bind bod_top bod_props props_i (
  .CLK         (CLK),
  .RST_N       (RST_N),
  .pready      (pready),
  .pslverr     (pslverr),
  .bod_int     (bod_int),
  .bor_rst_req (bor_rst_req),
  .vwarn       (mon_if.vwarn),
  .vcrit       (mon_if.vcrit),
  .int_en      (regs_i.int_en),
  .bor_clr     (mon_if.bor_clr),
  .state       (seq_i.state)
);

`default_nettype wire

// File: dv/bod_tb.sv
`default_nettype none

module bod_tb;

  // ------------------------------------------------------------------
  // Timing and stimulus constants
  // ------------------------------------------------------------------
  localparam int unsigned CLK_PERIOD   = 100;
  localparam int unsigned RST_CYCLES   = 5;
  localparam int unsigned NOISE_CYCLES = 24;  // Random codes around TH1
  localparam int unsigned HOLD_CYCLES  = 20;  // Code kept low after a pulse
  // Watchdog budget, tests 1 to 6 then margin
  localparam int unsigned RUN_CYCLES   = RST_CYCLES + 40 + 60 + 30 + 30 + 80 + 30 + 100;

  localparam logic [7:0] TH1       = 8'h80;
  localparam logic [7:0] TH2       = 8'h40;
  localparam logic [7:0] CODE_OK   = 8'hC0;  // Above both release levels
  localparam logic [7:0] CODE_LOW  = 8'h70;  // Under TH1 only
  localparam logic [7:0] CODE_CRIT = 8'h30;  // Under both

  logic                       CLK;
  logic                       RST_N;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [bod_pkg::ADDR_W-1:0] paddr;
  logic [bod_pkg::DATA_W-1:0] pwdata;
  logic [bod_pkg::DATA_W-1:0] prdata;
  logic                       pready;
  logic                       pslverr;
  logic [bod_pkg::CODE_W-1:0] vdd_code;
  logic                       bod_int;
  logic                       bor_rst_req;

  int unsigned err_cnt;     // Failed read and output checks
  int unsigned pulse_cnt;   // Reset request pulses seen
  logic        req_seen;
  integer      seed;
  logic [31:0] rnd;
  logic [7:0]  code;
  int unsigned run;         // Consecutive samples under TH1
  logic        exp_sticky;  // Sticky bit predicted from the debounce rule
  int unsigned len;
  int unsigned pulses;
  logic [31:0] rdata;
  logic        err;

  bod_top bod_top_i (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Rising edges of the reset request, sampled away from the active edge
  always @(negedge CLK) begin
    if (bor_rst_req && !req_seen) pulse_cnt++;
    req_seen = bor_rst_req;
  end

  // ------------------------------------------------------------------
  // Helpers, entered and left on a falling edge
  // ------------------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic slverr);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge CLK);
    penable = 1'b1;  // Access phase
    #(CLK_PERIOD / 4);
    while (pready !== 1'b1) begin
      @(negedge CLK);
      #(CLK_PERIOD / 4);
    end
    rd     = prdata;  // Settled mid low phase
    slverr = pslverr;
    @(negedge CLK);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else begin
        err_cnt++;
        $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      end
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        slverr;
    apb_xfer(1'b1, addr, data, rd, slverr);
    check_val("apb write pslverr", 32'd0, {31'd0, slverr});
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] rd, output logic slverr);
    apb_xfer(1'b0, addr, 32'd0, rd, slverr);
  endtask

  task automatic check_reg(input string name, input logic [4:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        slverr;
    apb_read(addr, rd, slverr);
    check_val(name, exp, rd);
    check_val({name, " pslverr"}, 32'd0, {31'd0, slverr});
  endtask

  task automatic set_code(input logic [7:0] c, input int unsigned cycles);
    vdd_code = c;
    repeat (cycles) @(negedge CLK);
  endtask

  // Waits for a request, then counts its falling-edge samples
  task automatic measure_pulse(output int unsigned n);
    n = 0;
    while (bor_rst_req !== 1'b1) @(negedge CLK);
    while (bor_rst_req === 1'b1) begin
      n++;
      @(negedge CLK);
    end
  endtask

  // ------------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------------
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", RUN_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    seed       = 32'h7b65ac10;
    err_cnt    = 0;
    pulse_cnt  = 0;
    req_seen   = 1'b0;
    exp_sticky = 1'b0;
    run        = 0;
    CLK        = 1'b0;
    RST_N      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    vdd_code   = 8'hFF;  // Healthy supply
    repeat (RST_CYCLES) @(negedge CLK);
    RST_N = 1'b1;
    @(negedge CLK);

    // Test 1, register access
    check_reg("t1 v_th1 reset", bod_pkg::REG_V_TH1, 32'd0);
    check_reg("t1 v_th2 reset", bod_pkg::REG_V_TH2, 32'd0);
    check_reg("t1 status reset", bod_pkg::REG_STATUS, 32'd0);
    check_reg("t1 ctrl reset", bod_pkg::REG_CTRL, 32'd1);
    check_reg("t1 bor status reset", bod_pkg::REG_BOR_STATUS, 32'd0);
    apb_write(bod_pkg::REG_V_TH1, 32'h1234_56C3);
    check_reg("t1 v_th1 readback", bod_pkg::REG_V_TH1, 32'h0000_00C3);
    apb_write(bod_pkg::REG_V_TH2, 32'hFFFF_FF3C);
    check_reg("t1 v_th2 readback", bod_pkg::REG_V_TH2, 32'h0000_003C);
    apb_read(5'h18, rdata, err);
    check_val("t1 unmapped read data", 32'd0, rdata);
    check_val("t1 unmapped read pslverr", 32'd1, {31'd0, err});
    apb_xfer(1'b1, 5'h18, 32'hFFFF_FFFF, rdata, err);
    check_val("t1 unmapped write pslverr", 32'd1, {31'd0, err});
    check_reg("t1 v_th1 after unmapped write", bod_pkg::REG_V_TH1, 32'h0000_00C3);
    check_reg("t1 bor_clr reads 0", bod_pkg::REG_BOR_CLR, 32'd0);

    // Test 2, debounced warning
    apb_write(bod_pkg::REG_V_TH1, {24'd0, TH1});
    set_code(CODE_LOW, bod_pkg::DEBOUNCE_CYCLES - 1);  // One sample short
    set_code(CODE_OK, 0);
    check_reg("t2 short dip", bod_pkg::REG_STATUS, 32'd0);
    check_val("t2 short dip bod_int", 32'd0, {31'd0, bod_int});
    for (int i = 0; i < NOISE_CYCLES; i++) begin
      rnd  = $random(seed);
      code = CODE_LOW + {3'b000, rnd[4:0]};  // 0x70 to 0x8F
      run  = (code < TH1) ? run + 1 : 0;
      if (run >= bod_pkg::DEBOUNCE_CYCLES) exp_sticky = 1'b1;
      set_code(code, 1);
    end
    set_code(CODE_OK, 0);
    check_reg("t2 noise sticky", bod_pkg::REG_STATUS, {31'd0, exp_sticky});
    apb_write(bod_pkg::REG_STATUS, 32'd1);
    check_reg("t2 status cleared", bod_pkg::REG_STATUS, 32'd0);
    set_code(CODE_LOW, bod_pkg::DEBOUNCE_CYCLES);
    check_reg("t2 warning", bod_pkg::REG_STATUS, 32'd3);
    check_val("t2 bod_int", 32'd1, {31'd0, bod_int});

    // Test 3, hysteresis and W1C
    set_code(TH1 + 8'd2, 2);
    check_reg("t3 inside band", bod_pkg::REG_STATUS, 32'd3);
    set_code(TH1 + bod_pkg::HYST_CODES, 1);
    check_reg("t3 above band", bod_pkg::REG_STATUS, 32'd1);
    apb_write(bod_pkg::REG_STATUS, 32'd0);
    check_reg("t3 write 0 keeps", bod_pkg::REG_STATUS, 32'd1);
    check_val("t3 bod_int kept", 32'd1, {31'd0, bod_int});
    apb_write(bod_pkg::REG_STATUS, 32'd1);
    check_reg("t3 W1C", bod_pkg::REG_STATUS, 32'd0);
    check_val("t3 bod_int dropped", 32'd0, {31'd0, bod_int});

    // Test 4, interrupt masking
    apb_write(bod_pkg::REG_CTRL, 32'd0);
    check_reg("t4 ctrl off", bod_pkg::REG_CTRL, 32'd0);
    set_code(CODE_LOW, bod_pkg::DEBOUNCE_CYCLES + 1);
    set_code(CODE_OK, 1);
    check_reg("t4 masked sticky", bod_pkg::REG_STATUS, 32'd1);
    check_val("t4 bod_int masked", 32'd0, {31'd0, bod_int});
    apb_write(bod_pkg::REG_CTRL, 32'd1);
    check_val("t4 bod_int unmasked", 32'd1, {31'd0, bod_int});
    apb_write(bod_pkg::REG_STATUS, 32'd1);

    // Test 5, brownout reset
    apb_write(bod_pkg::REG_V_TH2, {24'd0, TH2});
    set_code(CODE_CRIT, 0);
    measure_pulse(len);
    check_val("t5 first pulse length", bod_pkg::BOR_PULSE_CYCLES, len);
    check_val("t5 first pulse count", 32'd1, pulse_cnt);
    check_reg("t5 bor status", bod_pkg::REG_BOR_STATUS, 32'd3);
    pulses = pulse_cnt;
    set_code(CODE_CRIT, HOLD_CYCLES);
    check_val("t5 no retrigger", pulses, pulse_cnt);
    set_code(CODE_OK, 3);  // vcrit falls, FSM re-arms
    set_code(CODE_CRIT, 0);
    measure_pulse(len);
    check_val("t5 second pulse length", bod_pkg::BOR_PULSE_CYCLES, len);
    check_val("t5 second pulse count", pulses + 1, pulse_cnt);

    // Test 6, BOR clear
    set_code(CODE_OK, 3);
    check_reg("t6 event before clear", bod_pkg::REG_BOR_STATUS, 32'd1);
    apb_write(bod_pkg::REG_BOR_CLR, 32'd0);
    check_reg("t6 write 0 keeps event", bod_pkg::REG_BOR_STATUS, 32'd1);
    apb_write(bod_pkg::REG_BOR_CLR, 32'd1);
    check_reg("t6 event cleared", bod_pkg::REG_BOR_STATUS, 32'd0);
    check_reg("t6 bor_clr reads 0", bod_pkg::REG_BOR_CLR, 32'd0);

    $display("Summary: %0d check errors, %0d assertion failures",
             err_cnt, bod_top_i.props_i.fail_cnt);
    if (err_cnt == 0 && bod_top_i.props_i.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
src/bod_pkg.sv
src/bod_mon_if.sv
src/bod_regs.sv
src/bod_monitor.sv
src/bod_bor_seq.sv
src/bod_top.sv
dv/bod_props.sv
dv/bod_tb.sv

// File: Bender.yml
package:
  name: bod

sources:
  - src/bod_pkg.sv
  - src/bod_mon_if.sv
  - src/bod_regs.sv
  - src/bod_monitor.sv
  - src/bod_bor_seq.sv
  - src/bod_top.sv
  - target: simulation
    files:
      - dv/bod_props.sv
      - dv/bod_tb.sv
